//--- bus_pkg.sv
package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // AXI4-Lite channel payloads, valid and ready travel beside them.
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axi_r_t;

  // Native memory side.
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;  // Zero for a read.
  } nmi_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } nmi_rsp_t;

endpackage

//--- soc_pkg.sv
package soc_pkg;

  // Top address byte of each physical bank.
  localparam logic [7:0] BOOT_BASE = 8'h00;
  localparam logic [7:0] DATA_BASE = 8'h40;

  // Alias windows seen by the core.
  localparam logic [7:0] BOOT_ALIAS = 8'h30;  // Maps onto BOOT_BASE.
  localparam logic [7:0] DATA_ALIAS = 8'ha0;  // Maps onto DATA_BASE.

  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = 8;

  // Wait states, request to ready.
  localparam int unsigned          WAIT_W    = 2;
  localparam logic [WAIT_W-1:0]    BOOT_WAIT = 2'd3;
  localparam logic [WAIT_W-1:0]    DATA_WAIT = 2'd1;

  // Core side stays in reset this long after the system reset ends.
  localparam int unsigned          RST_CNT_W = 5;
  localparam logic [RST_CNT_W-1:0] RST_DELAY = 5'd16;

endpackage

//--- rst_delay.sv
`timescale 1ns/1ns

module rst_delay (
  input  logic clk_i,
  input  logic rst_i,
  output logic core_rst_o
);

  logic [soc_pkg::RST_CNT_W-1:0] cnt_q;
  logic                          done;

  assign done = (cnt_q == soc_pkg::RST_DELAY);

  // Counts up once per cycle after rst_i drops and parks at the limit.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (!done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign core_rst_o = !done;  // Held until the count completes.

endmodule

//--- axi_lite_nmi_bridge.sv
`timescale 1ns/1ns

module axi_lite_nmi_bridge (
  input  logic              clk_i,
  input  logic              rst_i,
  input  bus_pkg::axi_aw_t  aw_i,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  bus_pkg::axi_w_t   w_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  output bus_pkg::axi_b_t   b_o,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  input  bus_pkg::axi_ar_t  ar_i,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  output bus_pkg::axi_r_t   r_o,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic              mem_valid_o,
  output bus_pkg::nmi_req_t mem_req_o,
  input  logic              mem_ready_i,
  input  bus_pkg::nmi_rsp_t mem_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WREQ,
    ST_RREQ,
    ST_RSP
  } state_e;

  state_e                     state_q;
  logic                       wr_ready_q;
  logic                       ar_ready_q;
  logic                       wr_pair;
  logic                       wr_hs;
  logic                       rd_hs;
  logic                       rsp_taken;
  logic [bus_pkg::DATA_W-1:0] rdata_q;

  // Folds the alias windows onto the physical banks.
  function automatic logic [bus_pkg::ADDR_W-1:0] remap(
    input logic [bus_pkg::ADDR_W-1:0] addr
  );
    logic [7:0]                 top;
    logic [bus_pkg::ADDR_W-1:0] res;
    top = addr[bus_pkg::ADDR_W-1 -: 8];
    res = addr;
    if (top == soc_pkg::BOOT_ALIAS) begin
      res[bus_pkg::ADDR_W-1 -: 8] = soc_pkg::BOOT_BASE;
    end else if (top == soc_pkg::DATA_ALIAS) begin
      res[bus_pkg::ADDR_W-1 -: 8] = soc_pkg::DATA_BASE;
    end
    return res;
  endfunction

  always_comb begin
    wr_pair   = aw_valid_i && w_valid_i;
    wr_hs     = wr_ready_q && wr_pair;
    rd_hs     = ar_ready_q && ar_valid_i;
    rsp_taken = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ST_IDLE;
      wr_ready_q  <= 1'b0;
      ar_ready_q  <= 1'b0;
      mem_valid_o <= 1'b0;
      b_valid_o   <= 1'b0;
      r_valid_o   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          wr_ready_q <= 1'b0;  // Readies last one cycle.
          ar_ready_q <= 1'b0;
          if (wr_hs) begin
            state_q     <= ST_WREQ;
            mem_valid_o <= 1'b1;
          end else if (rd_hs) begin
            state_q     <= ST_RREQ;
            mem_valid_o <= 1'b1;
          end else if (wr_pair) begin
            wr_ready_q <= 1'b1;  // Writes win a tie.
          end else if (ar_valid_i) begin
            ar_ready_q <= 1'b1;
          end
        end
        ST_WREQ: begin
          if (mem_ready_i) begin
            mem_valid_o <= 1'b0;
            b_valid_o   <= 1'b1;
            state_q     <= ST_RSP;
          end
        end
        ST_RREQ: begin
          if (mem_ready_i) begin
            mem_valid_o <= 1'b0;
            r_valid_o   <= 1'b1;
            state_q     <= ST_RSP;
          end
        end
        ST_RSP: begin
          // Nothing new is accepted until the master takes the response.
          if (rsp_taken) begin
            b_valid_o <= 1'b0;
            r_valid_o <= 1'b0;
            state_q   <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Request and read data hold their value between transactions.
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      mem_req_o <= '{addr: remap(aw_i.addr), wdata: w_i.data, wstrb: w_i.strb};
    end else if (rd_hs) begin
      mem_req_o <= '{addr: remap(ar_i.addr), wdata: '0, wstrb: '0};
    end
    if (state_q == ST_RREQ && mem_ready_i) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  assign aw_ready_o = wr_ready_q;
  assign w_ready_o  = wr_ready_q;
  assign ar_ready_o = ar_ready_q;

  // No error path on the native side.
  assign b_o = '{resp: bus_pkg::RESP_OKAY};
  assign r_o = '{data: rdata_q, resp: bus_pkg::RESP_OKAY};

endmodule

//--- nmi_mem.sv
`timescale 1ns/1ns

module nmi_mem (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              mem_valid_i,
  input  bus_pkg::nmi_req_t mem_req_i,
  output logic              mem_ready_o,
  output bus_pkg::nmi_rsp_t mem_rsp_o
);

  logic [7:0]                  top_byte;
  logic                        hit_boot;
  logic                        hit_data;
  logic                        hit;
  logic                        bank;
  logic [soc_pkg::BANK_AW-1:0] word_idx;
  logic [soc_pkg::WAIT_W-1:0]  wait_len;
  logic [soc_pkg::WAIT_W-1:0]  load_cnt;
  logic [soc_pkg::WAIT_W-1:0]  cnt_q;
  logic [soc_pkg::WAIT_W-1:0]  cnt_d;
  logic                        start;
  logic                        ready_d;
  logic [bus_pkg::DATA_W-1:0]  rdata_q;

  // Bank 0 is boot, bank 1 is data.
  logic [bus_pkg::DATA_W-1:0] mem_q [2][soc_pkg::BANK_WORDS];

  always_comb begin
    top_byte = mem_req_i.addr[bus_pkg::ADDR_W-1 -: 8];
    hit_boot = (top_byte == soc_pkg::BOOT_BASE);
    hit_data = (top_byte == soc_pkg::DATA_BASE);
    hit      = hit_boot || hit_data;
    bank     = hit_data;
    word_idx = mem_req_i.addr[soc_pkg::BANK_AW+1:2];  // Upper offset bits alias.
    wait_len = hit_boot ? soc_pkg::BOOT_WAIT : soc_pkg::DATA_WAIT;
    load_cnt = wait_len - 1'b1;
  end

  // Remaining edges until ready, zero when no request is in flight.
  always_comb begin
    start   = mem_valid_i && (cnt_q == '0) && !mem_ready_o;
    cnt_d   = cnt_q;
    ready_d = 1'b0;
    if (start) begin
      cnt_d   = load_cnt;
      ready_d = (load_cnt == '0);
    end else if (cnt_q != '0) begin
      cnt_d   = cnt_q - 1'b1;
      ready_d = (cnt_d == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q       <= '0;
      mem_ready_o <= 1'b0;
    end else begin
      cnt_q       <= cnt_d;
      mem_ready_o <= ready_d;  // One cycle pulse.
    end
  end

  // Read word is fetched as ready is raised; unmapped returns zero.
  always_ff @(posedge clk_i) begin
    if (ready_d) begin
      rdata_q <= hit ? mem_q[bank][word_idx] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_ready_o && hit) begin
      for (int b = 0; b < bus_pkg::STRB_W; b++) begin
        if (mem_req_i.wstrb[b]) begin
          mem_q[bank][word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign mem_rsp_o = '{rdata: rdata_q};

endmodule

//--- core_bus_top.sv
`timescale 1ns/1ns

module core_bus_top (
  input  logic             clk_i,
  input  logic             rst_i,
  input  bus_pkg::axi_aw_t aw_i,
  input  logic             aw_valid_i,
  output logic             aw_ready_o,
  input  bus_pkg::axi_w_t  w_i,
  input  logic             w_valid_i,
  output logic             w_ready_o,
  output bus_pkg::axi_b_t  b_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  input  bus_pkg::axi_ar_t ar_i,
  input  logic             ar_valid_i,
  output logic             ar_ready_o,
  output bus_pkg::axi_r_t  r_o,
  output logic             r_valid_o,
  input  logic             r_ready_i
);

  logic              core_rst;
  logic              mem_valid;
  bus_pkg::nmi_req_t mem_req;
  logic              mem_ready;
  bus_pkg::nmi_rsp_t mem_rsp;

  rst_delay u_rst_delay (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .core_rst_o(core_rst)
  );

  // Core-facing logic sits in the delayed reset domain.
  axi_lite_nmi_bridge u_axi_lite_nmi_bridge (
    .clk_i      (clk_i),
    .rst_i      (core_rst),
    .aw_i       (aw_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_i        (w_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_o        (b_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .ar_i       (ar_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_o        (r_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .mem_valid_o(mem_valid),
    .mem_req_o  (mem_req),
    .mem_ready_i(mem_ready),
    .mem_rsp_i  (mem_rsp)
  );

  nmi_mem u_nmi_mem (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .mem_valid_i(mem_valid),
    .mem_req_i  (mem_req),
    .mem_ready_o(mem_ready),
    .mem_rsp_o  (mem_rsp)
  );

endmodule

//--- tb_core_bus_top.sv
`timescale 1ns/1ns

module tb_core_bus_top;

  localparam int unsigned MAX_XACTS   = 300;
  localparam int unsigned XACT_CYCLES = 20;  // Worst case handshake plus wait states and delay.
  localparam int unsigned TIMEOUT_CYC = MAX_XACTS * XACT_CYCLES;

  typedef struct packed {
    logic                       is_rd;
    logic [bus_pkg::DATA_W-1:0] data;
  } exp_t;

  logic              clk_i = 1'b0;
  logic              rst_i;
  bus_pkg::axi_aw_t  aw_i;
  logic              aw_valid_i;
  logic              aw_ready_o;
  bus_pkg::axi_w_t   w_i;
  logic              w_valid_i;
  logic              w_ready_o;
  bus_pkg::axi_b_t   b_o;
  logic              b_valid_o;
  logic              b_ready_i;
  bus_pkg::axi_ar_t  ar_i;
  logic              ar_valid_i;
  logic              ar_ready_o;
  bus_pkg::axi_r_t   r_o;
  logic              r_valid_o;
  logic              r_ready_i;

  integer                     seed;
  int unsigned                n_checks = 0;
  int unsigned                n_errors = 0;
  int unsigned                n_issued = 0;
  int unsigned                n_rsp    = 0;
  int unsigned                n_cycles = 0;
  exp_t                       exp_q[$];
  logic                       probe_en = 1'b0;
  logic [bus_pkg::ADDR_W-1:0] probe_addr;
  logic [bus_pkg::DATA_W-1:0] probe_data;

  // Bank 0 is boot, bank 1 is data; contents start unknown like the DUT's.
  logic [bus_pkg::DATA_W-1:0] ref_mem [2][soc_pkg::BANK_WORDS];

  core_bus_top u_core_bus_top (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .aw_i      (aw_i),
    .aw_valid_i(aw_valid_i),
    .aw_ready_o(aw_ready_o),
    .w_i       (w_i),
    .w_valid_i (w_valid_i),
    .w_ready_o (w_ready_o),
    .b_o       (b_o),
    .b_valid_o (b_valid_o),
    .b_ready_i (b_ready_i),
    .ar_i      (ar_i),
    .ar_valid_i(ar_valid_i),
    .ar_ready_o(ar_ready_o),
    .r_o       (r_o),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i)
  );

  always #50 clk_i = ~clk_i;

  // Physical top byte after the alias windows are folded.
  function automatic logic [7:0] phys_top(input logic [bus_pkg::ADDR_W-1:0] addr);
    logic [7:0] top;
    top = addr[bus_pkg::ADDR_W-1 -: 8];
    if (top == soc_pkg::BOOT_ALIAS) begin
      top = soc_pkg::BOOT_BASE;
    end else if (top == soc_pkg::DATA_ALIAS) begin
      top = soc_pkg::DATA_BASE;
    end
    return top;
  endfunction

  // Cycles from the address handshake edge to the first edge that sees the response.
  function automatic int unsigned exp_latency(input logic [bus_pkg::ADDR_W-1:0] addr);
    if (phys_top(addr) == soc_pkg::BOOT_BASE) begin
      return 2 + soc_pkg::BOOT_WAIT;
    end
    return 2 + soc_pkg::DATA_WAIT;
  endfunction

  function automatic logic [bus_pkg::DATA_W-1:0] ref_access(
    input logic [bus_pkg::ADDR_W-1:0] addr,
    input logic [bus_pkg::DATA_W-1:0] data,
    input logic [bus_pkg::STRB_W-1:0] strb
  );
    logic [7:0]                  top;
    logic [soc_pkg::BANK_AW-1:0] idx;
    logic [bus_pkg::DATA_W-1:0]  word;
    int                          bank;
    top  = phys_top(addr);
    idx  = addr[soc_pkg::BANK_AW+1:2];
    word = '0;  // Unmapped reads return zero.
    if (top == soc_pkg::BOOT_BASE || top == soc_pkg::DATA_BASE) begin
      bank = (top == soc_pkg::DATA_BASE) ? 1 : 0;
      word = ref_mem[bank][idx];
      for (int b = 0; b < bus_pkg::STRB_W; b++) begin
        if (strb[b]) begin
          word[8*b +: 8] = data[8*b +: 8];
        end
      end
      ref_mem[bank][idx] = word;
    end
    return word;
  endfunction

  function automatic logic rsp_valid(input logic is_rd);
    return is_rd ? r_valid_o : b_valid_o;
  endfunction

  function automatic logic [63:0] rsp_word(input logic is_rd);
    if (is_rd) begin
      return r_o;
    end
    return b_o;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_rsp(input logic is_rd, input logic [bus_pkg::DATA_W-1:0] data);
    exp_q.push_back('{is_rd: is_rd, data: data});
    n_issued++;
  endtask

  task automatic rand_ready_delay(output int unsigned n);
    n = $unsigned($random(seed)) % 8;
  endtask

  // Holds the response ready low for a random time, then takes the response.
  task automatic await_response(input logic is_rd, input int unsigned exp_lat);
    int unsigned lat;
    int unsigned dly;
    logic [63:0] held;
    string       vld_name;
    string       pay_name;
    if (is_rd) begin
      vld_name = "r_valid_o";
      pay_name = "r_o";
    end else begin
      vld_name = "b_valid_o";
      pay_name = "b_o";
    end
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
      check_eq("aw_ready_o", aw_ready_o, 1'b0);
      check_eq("ar_ready_o", ar_ready_o, 1'b0);
    end while (!rsp_valid(is_rd) && lat < XACT_CYCLES);
    check_eq({vld_name, " latency"}, lat, exp_lat);
    held = rsp_word(is_rd);
    rand_ready_delay(dly);
    repeat (dly) begin
      @(posedge clk_i);
      check_eq("aw_ready_o", aw_ready_o, 1'b0);
      check_eq("ar_ready_o", ar_ready_o, 1'b0);
      check_eq(vld_name, rsp_valid(is_rd), 1'b1);
      check_eq(pay_name, rsp_word(is_rd), held);
    end
    if (is_rd) begin
      r_ready_i <= 1'b1;
    end else begin
      b_ready_i <= 1'b1;
    end
    @(posedge clk_i);  // Response taken on this edge.
    r_ready_i <= 1'b0;
    b_ready_i <= 1'b0;
  endtask

  task automatic axi_write(
    input logic [bus_pkg::ADDR_W-1:0] addr,
    input logic [bus_pkg::DATA_W-1:0] data,
    input logic [bus_pkg::STRB_W-1:0] strb
  );
    @(posedge clk_i);
    aw_i       <= '{addr: addr};
    w_i        <= '{data: data, strb: strb};
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    if (probe_en) begin
      ar_i       <= '{addr: probe_addr};  // Competes with the write pair.
      ar_valid_i <= 1'b1;
    end
    do begin
      @(posedge clk_i);
    end while (!aw_ready_o);
    check_eq("w_ready_o", w_ready_o, 1'b1);
    check_eq("ar_ready_o", ar_ready_o, 1'b0);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    void'(ref_access(addr, data, strb));
    expect_rsp(1'b0, '0);
    await_response(1'b0, exp_latency(addr));
  endtask

  task automatic axi_read(input logic [bus_pkg::ADDR_W-1:0] addr);
    @(posedge clk_i);
    ar_i       <= '{addr: addr};
    ar_valid_i <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (!ar_ready_o);
    ar_valid_i <= 1'b0;
    if (probe_en) begin
      aw_i       <= '{addr: probe_addr};  // Waits while the read response is held.
      w_i        <= '{data: probe_data, strb: 4'hf};
      aw_valid_i <= 1'b1;
      w_valid_i  <= 1'b1;
    end
    expect_rsp(1'b1, ref_access(addr, '0, '0));
    await_response(1'b1, exp_latency(addr));
  endtask

  task automatic report_test(input string name, input int unsigned err_at_start);
    if (n_errors == err_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, n_errors - err_at_start);
    end
  endtask

  // Responses are sampled mid-cycle half a period before the taking edge.
  always @(negedge clk_i) begin : compare_rsp
    exp_t e;
    if (b_valid_o && b_ready_i) begin
      n_rsp++;
      if (exp_q.size() == 0 || exp_q[0].is_rd) begin
        n_errors++;
        $display("write response at %0t ns while no write was pending", $time);
      end else begin
        e = exp_q.pop_front();
        check_eq("b_o.resp", b_o.resp, bus_pkg::RESP_OKAY);
      end
    end
    if (r_valid_o && r_ready_i) begin
      n_rsp++;
      if (exp_q.size() == 0 || !exp_q[0].is_rd) begin
        n_errors++;
        $display("read response at %0t ns while no read was pending", $time);
      end else begin
        e = exp_q.pop_front();
        check_eq("r_o.data", r_o.data, e.data);
        check_eq("r_o.resp", r_o.resp, bus_pkg::RESP_OKAY);
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    n_cycles++;
    if (n_cycles >= TIMEOUT_CYC) begin
      $display("run stopped after %0d cycles, a transaction never completed", n_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    int unsigned                err0;
    int unsigned                n;
    int unsigned                sel;
    logic [7:0]                 top;
    logic [bus_pkg::ADDR_W-1:0] addr;
    logic [31:0]                rnd;
    seed       = 47;
    rst_i      <= 1'b1;
    aw_i       <= '0;
    aw_valid_i <= 1'b0;
    w_i        <= '0;
    w_valid_i  <= 1'b0;
    b_ready_i  <= 1'b0;
    ar_i       <= '0;
    ar_valid_i <= 1'b0;
    r_ready_i  <= 1'b0;
    repeat (4) @(posedge clk_i);

    // All three address channels wait on the core-side reset.
    err0 = n_errors;
    addr = {soc_pkg::DATA_BASE, 24'h000000};
    aw_i       <= '{addr: addr};
    w_i        <= '{data: 32'h0bad_f00d, strb: 4'hf};
    ar_i       <= '{addr: addr};
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    ar_valid_i <= 1'b1;
    rst_i      <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      check_eq("b_valid_o", b_valid_o, 1'b0);
      check_eq("r_valid_o", r_valid_o, 1'b0);
    end while (!aw_ready_o && !ar_ready_o && n < soc_pkg::RST_DELAY + 8);
    // RST_DELAY edges release core_rst, one raises ready, one samples it.
    check_eq("first ready edge", n, soc_pkg::RST_DELAY + 2);
    check_eq("w_ready_o", w_ready_o, 1'b1);
    check_eq("ar_ready_o", ar_ready_o, 1'b0);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    ar_valid_i <= 1'b0;
    void'(ref_access(addr, 32'h0bad_f00d, 4'hf));
    expect_rsp(1'b0, '0);
    await_response(1'b0, exp_latency(addr));
    axi_read(addr);
    report_test("test 1 reset delay", err0);

    err0 = n_errors;
    axi_write({soc_pkg::DATA_BASE, 24'h000004}, 32'hdead_beef, 4'hf);
    axi_write({soc_pkg::DATA_BASE, 24'h000004}, 32'h1122_3344, 4'b0101);
    axi_read({soc_pkg::DATA_BASE, 24'h000004});
    axi_write({soc_pkg::BOOT_BASE, 24'h000008}, 32'hcafe_0123, 4'hf);
    axi_write({soc_pkg::BOOT_BASE, 24'h000008}, 32'h55aa_55aa, 4'b1000);
    axi_write({soc_pkg::BOOT_BASE, 24'h000008}, 32'h0000_7700, 4'b0010);
    axi_read({soc_pkg::BOOT_BASE, 24'h000008});
    report_test("test 2 direct access with strobes", err0);

    err0 = n_errors;
    axi_write({soc_pkg::BOOT_ALIAS, 24'h000010}, 32'h3000_0010, 4'hf);
    axi_read({soc_pkg::BOOT_BASE, 24'h000010});
    axi_write({soc_pkg::DATA_BASE, 24'h000014}, 32'h4000_0014, 4'hf);
    axi_read({soc_pkg::DATA_ALIAS, 24'h000014});
    axi_write({soc_pkg::DATA_BASE, 24'h000018}, 32'h0123_4567, 4'hf);
    axi_read({soc_pkg::DATA_BASE, 24'h008418});  // Same word with bits above 9 set.
    axi_write({soc_pkg::BOOT_ALIAS, 24'hfffc1c}, 32'h89ab_cdef, 4'hf);
    axi_read({soc_pkg::BOOT_BASE, 24'h00001c});
    report_test("test 3 alias remap", err0);

    err0 = n_errors;
    axi_write({soc_pkg::BOOT_BASE, 24'h000020}, 32'h1111_1111, 4'hf);
    axi_write({soc_pkg::DATA_BASE, 24'h000020}, 32'h2222_2222, 4'hf);
    axi_write({8'h12, 24'h000020}, 32'hffff_ffff, 4'hf);
    axi_write({8'hc0, 24'h000020}, 32'heeee_eeee, 4'hf);
    axi_read({soc_pkg::BOOT_BASE, 24'h000020});
    axi_read({soc_pkg::DATA_BASE, 24'h000020});
    axi_read({8'h12, 24'h000020});
    report_test("test 4 unmapped addresses", err0);

    // Each held response has a transaction of the other kind waiting on its valid.
    err0 = n_errors;
    for (int i = 0; i < 10; i++) begin
      rnd        = $random(seed);
      top        = rnd[31] ? soc_pkg::DATA_BASE : soc_pkg::BOOT_BASE;
      addr       = {top, 18'h0, rnd[3:0], 2'b00};
      probe_addr = addr;
      probe_data = $random(seed);
      probe_en   = 1'b1;
      axi_write(addr, $random(seed), 4'hf);
      axi_read(addr);
      probe_en   = 1'b0;
      axi_write(addr, probe_data, 4'hf);  // Pair raised during the read.
    end
    report_test("test 5 back-pressure", err0);

    err0 = n_errors;
    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      sel = $unsigned($random(seed)) % 5;
      case (sel)
        0: top = soc_pkg::BOOT_BASE;
        1: top = soc_pkg::DATA_BASE;
        2: top = soc_pkg::BOOT_ALIAS;
        3: top = soc_pkg::DATA_ALIAS;
        default: top = rnd[31:24];
      endcase
      addr = {top, rnd[23:10], 4'h0, rnd[3:0], 2'b00};  // 16 words whose high offsets alias.
      if (rnd[8]) begin
        axi_write(addr, $random(seed), rnd[7:4]);
      end else begin
        axi_read(addr);
      end
    end
    report_test("test 6 random traffic", err0);

    repeat (2) @(posedge clk_i);
    if (exp_q.size() != 0 || n_rsp != n_issued) begin
      n_errors++;
      $display("%0d transactions issued but %0d responses seen", n_issued, n_rsp);
    end
    $display("%0d checks, %0d errors, %0d transactions", n_checks, n_errors, n_issued);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
bus_pkg.sv
soc_pkg.sv
rst_delay.sv
axi_lite_nmi_bridge.sv
nmi_mem.sv
core_bus_top.sv
tb_core_bus_top.sv

//--- Bender.yml
package:
  name: core_bus

sources:
  # Packages come first, the other files use their types.
  - bus_pkg.sv
  - soc_pkg.sv
  - rst_delay.sv
  - axi_lite_nmi_bridge.sv
  - nmi_mem.sv
  - core_bus_top.sv
  - target: test
    files:
      - tb_core_bus_top.sv
